/* flist.f */
+incdir+design
design/cache_addr_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_controller.sv
design/l1_cache.sv
verif/tb_main_memory.sv
verif/tb_l1_cache.sv

/* run_sim.sh */
#!/bin/sh
# builds the L1 cache testbench with Verilator, runs it, checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_l1_cache \
    -o sim_l1_cache

./obj_dir/sim_l1_cache > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* verif/tb_l1_cache.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_l1_cache;

    localparam int CLK_PERIOD   = 100;
    localparam int DIRECTED_OPS = 16;
    localparam int RANDOM_OPS   = 400;
    localparam int NUM_OPS      = DIRECTED_OPS + RANDOM_OPS;
    localparam int WATCHDOG_NS  = NUM_OPS * 16 * CLK_PERIOD;
    localparam int ACCESS_LIMIT = 16;   // dirty miss with slowest memory is 13

    logic                       clk;
    logic                       proc_reset;
    logic                       proc_read;
    logic                       proc_write;
    cache_addr_pkg::proc_addr_t proc_addr;
    cache_addr_pkg::word_t      proc_wdata;
    logic                       proc_stall;
    cache_addr_pkg::word_t      proc_rdata;
    logic                       mem_read;
    logic                       mem_write;
    cache_addr_pkg::mem_addr_t  mem_addr;
    cache_addr_pkg::block_t     mem_wdata;
    cache_addr_pkg::block_t     mem_rdata;
    logic                       mem_ready;
    int                         read_count;
    int                         write_count;
    int                         range_errors;

    cache_addr_pkg::word_t exp_mem [128];   // every word reachable with tags 0..7
    logic [4:0] resident [4][2];            // {valid, dirty, tag}, slot 0 most recent
    int          exp_reads;
    int          exp_writes;
    int          mismatch_count;
    int          timeout_count;
    logic        aborted;
    logic [31:0] op;
    integer      seed;

    l1_cache dut (.*);
    tb_main_memory main_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        mismatch_count++;
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d out of range, %0d timeouts",
                 mismatch_count, range_errors, timeout_count);
    endtask

    task automatic run_access(input logic wr, input logic [6:0] a,
                              input cache_addr_pkg::word_t wd);
        logic [1:0]             set;
        logic [4:0]             victim;
        logic                   pred_hit;
        logic                   pred_wb;
        logic                   hit_slot;
        logic                   done;
        logic                   prev_rd;
        logic                   prev_wr;
        cache_addr_pkg::block_t victim_data;
        cache_addr_pkg::word_t  got;
        int                     cycles;
        int                     reads;
        int                     writes;

        set      = a[3:2];
        victim   = resident[set][1];
        pred_hit = 1'b0;
        hit_slot = 1'b0;
        for (int s = 0; s < 2; s++) begin
            if (resident[set][s][4] && resident[set][s][2:0] == a[6:4]) begin
                pred_hit = 1'b1;
                hit_slot = s[0];
            end
        end
        pred_wb = !pred_hit && victim[4] && victim[3];
        for (int w = 0; w < 4; w++) begin
            victim_data[w*`CACHE_WORD_W +: `CACHE_WORD_W] = exp_mem[{victim[2:0], set, w[1:0]}];
        end

        @(posedge clk);
        proc_read  <= !wr;
        proc_write <= wr;
        proc_addr  <= cache_addr_pkg::proc_addr_t'(a);
        proc_wdata <= wd;

        cycles  = 0;
        reads   = 0;
        writes  = 0;
        done    = 1'b0;
        prev_rd = 1'b0;
        prev_wr = 1'b0;
        got     = '0;
        while (!done && cycles < ACCESS_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (mem_read && !prev_rd) begin   // new refill request
                reads++;
                assert (mem_addr == cache_addr_pkg::mem_addr_t'(a[6:2])) else
                    report_mismatch($sformatf("refill address %h for word %h", mem_addr, a));
            end
            if (mem_write && !prev_wr) begin
                writes++;
                assert (pred_wb && mem_addr == cache_addr_pkg::mem_addr_t'({victim[2:0], set})
                        && mem_wdata == victim_data) else
                    report_mismatch($sformatf("write-back of block %h data %h", mem_addr, mem_wdata));
            end
            prev_rd = mem_read;
            prev_wr = mem_write;
            done    = !proc_stall;
            got     = proc_rdata;
        end

        if (!done) begin
            $display("access to word %h still stalled after %0d cycles", a, ACCESS_LIMIT);
            timeout_count++;
            aborted = 1'b1;
            return;
        end

        assert ((cycles == 1) == pred_hit) else
            report_mismatch($sformatf("word %h predicted hit %0b, took %0d cycles",
                                      a, pred_hit, cycles));
        assert (reads == (pred_hit ? 0 : 1)) else
            report_mismatch($sformatf("word %h issued %0d refills", a, reads));
        assert (writes == (pred_wb ? 1 : 0)) else
            report_mismatch($sformatf("word %h issued %0d write-backs", a, writes));
        if (!wr) begin
            assert (got == exp_mem[a]) else
                report_mismatch($sformatf("read %h got %h expected %h", a, got, exp_mem[a]));
        end

        exp_reads  += pred_hit ? 0 : 1;
        exp_writes += pred_wb ? 1 : 0;
        if (wr) begin
            exp_mem[a] = wd;
        end
        if (pred_hit && hit_slot) begin
            resident[set][1] = resident[set][0];
            resident[set][0] = victim;   // slot 1 was the one that hit
        end else if (!pred_hit) begin
            resident[set][1] = resident[set][0];
            resident[set][0] = {1'b1, wr, a[6:4]};
        end
        if (wr) begin
            resident[set][0][3] = 1'b1;
        end
    endtask

    initial begin
        seed           = 32'h7458;
        proc_reset     = 1'b1;
        proc_read      = 1'b0;
        proc_write     = 1'b0;
        proc_addr      = '0;
        proc_wdata     = '0;
        exp_reads      = 0;
        exp_writes     = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        aborted        = 1'b0;
        for (int i = 0; i < 128; i++) begin
            exp_mem[i] = i ^ 32'hA5A5_0000;
        end
        for (int s = 0; s < 4; s++) begin
            resident[s][0] = '0;
            resident[s][1] = '0;
        end

        repeat (5) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        assert (!proc_stall && !mem_read && !mem_write) else
            report_mismatch("stall or memory request high after reset");

        // dirty block pushed out by two other tags, then read back
        for (int s = 0; s < 4; s++) begin
            run_access(1'b1, {3'd0, s[1:0], s[1:0]}, $random(seed));
            run_access(1'b0, {3'd1, s[1:0], 2'd0}, '0);
            run_access(1'b0, {3'd2, s[1:0], 2'd1}, '0);
            run_access(1'b0, {3'd0, s[1:0], s[1:0]}, '0);
        end

        for (int i = 0; i < RANDOM_OPS && !aborted; i++) begin
            op = $random(seed);
            if (op[15:13] == 3'd0) begin
                @(posedge clk);   // idle cycle
                proc_read  <= 1'b0;
                proc_write <= 1'b0;
            end
            run_access(op[8], op[6:0], $random(seed));
        end

        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(negedge clk);
        assert (read_count == exp_reads && write_count == exp_writes) else
            report_mismatch($sformatf("memory saw %0d reads %0d writes, expected %0d and %0d",
                                      read_count, write_count, exp_reads, exp_writes));

        print_counts();
        if (mismatch_count + range_errors + timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(negedge clk) begin
        if (!proc_reset) begin
            assert (!(mem_read && mem_write)) else
                report_mismatch("mem_read and mem_write both high");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t ns before all accesses finished", $time);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* verif/tb_main_memory.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_main_memory (
    input  logic                      clk,
    input  logic                      proc_reset,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  cache_addr_pkg::mem_addr_t mem_addr,
    input  cache_addr_pkg::block_t    mem_wdata,
    output cache_addr_pkg::block_t    mem_rdata,
    output logic                      mem_ready,
    output int                        read_count,
    output int                        write_count,
    output int                        range_errors
);

    localparam int BLOCKS = 32;   // tags 0..7 times 4 sets

    cache_addr_pkg::block_t store [BLOCKS];

    integer     seed;
    logic       busy;
    int         wait_cycles;
    logic [4:0] blk;

    assign blk = mem_addr[4:0];

    initial begin
        seed      = 32'h7458;
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int b = 0; b < BLOCKS; b++) begin
            for (int w = 0; w < `CACHE_BLOCK_WORDS; w++) begin
                // word address xor a fixed tag
                store[b][w*`CACHE_WORD_W +: `CACHE_WORD_W] = (b * 4 + w) ^ 32'hA5A5_0000;
            end
        end
    end

    always @(posedge clk) begin
        if (proc_reset) begin
            mem_ready    <= 1'b0;
            busy         <= 1'b0;
            wait_cycles  <= 0;
            read_count   <= 0;
            write_count  <= 0;
            range_errors <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;   // one ready pulse per request
            busy      <= 1'b0;
            if (mem_write) begin
                store[blk] <= mem_wdata;
            end
        end else if (busy) begin
            if (wait_cycles == 1) begin
                mem_ready <= 1'b1;
                mem_rdata <= store[blk];
            end
            wait_cycles <= wait_cycles - 1;
        end else if (mem_read || mem_write) begin
            busy        <= 1'b1;
            wait_cycles <= 1 + ({$random(seed)} % 4);   // 1 to 4 cycles
            if (mem_write) begin
                write_count <= write_count + 1;
            end else begin
                read_count <= read_count + 1;
            end
            assert (mem_addr[`MEM_ADDR_W-1:5] == '0) else begin
                $display("mismatch at %0t ns: memory address %h beyond the 32 modeled blocks",
                         $time, mem_addr);
                range_errors <= range_errors + 1;
            end
        end
    end

endmodule

/* design/l1_cache.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module l1_cache (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       proc_read,
    input  logic                       proc_write,
    input  cache_addr_pkg::proc_addr_t proc_addr,
    input  cache_addr_pkg::word_t      proc_wdata,
    input  cache_addr_pkg::block_t     mem_rdata,
    input  logic                       mem_ready,
    output logic                       proc_stall,
    output cache_addr_pkg::word_t      proc_rdata,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_addr_pkg::mem_addr_t  mem_addr,
    output cache_addr_pkg::block_t     mem_wdata
);

    cache_addr_pkg::tag_t    tag;
    cache_addr_pkg::index_t  index;
    cache_addr_pkg::offset_t offset;

    logic                   hit;
    logic                   victim_dirty;
    logic                   touch;
    logic                   fill;
    logic                   word_write;
    cache_ctrl_pkg::way_t   hit_way;
    cache_ctrl_pkg::way_t   victim_way;
    cache_ctrl_pkg::way_t   access_way;
    cache_addr_pkg::tag_t   victim_tag;
    cache_addr_pkg::block_t victim_block;

    // tag | index | word offset
    assign tag    = proc_addr[`PROC_ADDR_W-1 -: `CACHE_TAG_W];
    assign index  = proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign offset = proc_addr[`CACHE_OFFSET_W-1:0];

    cache_tag_array u_tags (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .tag          (tag),
        .touch        (touch),
        .fill         (fill),
        .access_way   (access_way),
        .set_dirty    (proc_write),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_data_array u_data (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .offset       (offset),
        .way          (access_way),
        .word_write   (word_write),
        .fill         (fill),
        .wdata        (proc_wdata),
        .fill_block   (mem_rdata),
        .merge_write  (proc_write),
        .rdata_word   (proc_rdata),
        .victim_block (victim_block)
    );

    cache_controller u_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .index        (index),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_block (victim_block),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .touch        (touch),
        .fill         (fill),
        .word_write   (word_write),
        .access_way   (access_way),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

/* design/cache_controller.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_controller (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       proc_read,
    input  logic                       proc_write,
    input  cache_addr_pkg::index_t     index,
    input  cache_addr_pkg::proc_addr_t proc_addr,
    input  logic                       hit,
    input  cache_ctrl_pkg::way_t       hit_way,
    input  cache_ctrl_pkg::way_t       victim_way,
    input  logic                       victim_dirty,
    input  cache_addr_pkg::tag_t       victim_tag,
    input  cache_addr_pkg::block_t     victim_block,
    input  logic                       mem_ready,
    output logic                       proc_stall,
    output logic                       touch,
    output logic                       fill,
    output logic                       word_write,
    output cache_ctrl_pkg::way_t       access_way,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_addr_pkg::mem_addr_t  mem_addr,
    output cache_addr_pkg::block_t     mem_wdata
);

    cache_ctrl_pkg::cache_state_t state;
    cache_ctrl_pkg::cache_state_t state_next;

    logic                      access;
    logic                      idle_miss;
    cache_addr_pkg::mem_addr_t refill_addr;

    assign access      = proc_read | proc_write;
    assign idle_miss   = (state == cache_ctrl_pkg::IDLE) && access && !hit;
    assign refill_addr = proc_addr[`PROC_ADDR_W-1:`CACHE_OFFSET_W];

    // hit way while serving a hit, victim way for everything else
    assign access_way = (state == cache_ctrl_pkg::IDLE && hit) ? hit_way : victim_way;

    always_comb begin
        state_next = state;
        proc_stall = 1'b0;
        touch      = 1'b0;
        fill       = 1'b0;
        word_write = 1'b0;
        case (state)
            cache_ctrl_pkg::IDLE: begin
                if (access && hit) begin
                    touch      = 1'b1;
                    word_write = proc_write;
                end else if (access) begin
                    proc_stall = 1'b1;
                    state_next = victim_dirty ? cache_ctrl_pkg::WRITEBACK
                                              : cache_ctrl_pkg::ALLOCATE;
                end
            end
            cache_ctrl_pkg::WRITEBACK: begin
                proc_stall = 1'b1;
                if (mem_ready) begin
                    state_next = cache_ctrl_pkg::ALLOCATE;
                end
            end
            cache_ctrl_pkg::ALLOCATE: begin
                proc_stall = !mem_ready;   // released in the refill cycle
                if (mem_ready) begin
                    fill       = 1'b1;
                    touch      = 1'b1;
                    state_next = cache_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_next = cache_ctrl_pkg::IDLE;
            end
        endcase
    end

    // state and request strobes
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state     <= cache_ctrl_pkg::IDLE;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            state <= state_next;
            if (idle_miss) begin
                mem_write <= victim_dirty;
                mem_read  <= !victim_dirty;
            end else if (state == cache_ctrl_pkg::WRITEBACK && mem_ready) begin
                mem_write <= 1'b0;
                mem_read  <= 1'b1;   // refill follows the write-back
            end else if (state == cache_ctrl_pkg::ALLOCATE && mem_ready) begin
                mem_read <= 1'b0;
            end
        end
    end

    // request address and data, held until mem_ready
    always_ff @(posedge clk) begin
        if (idle_miss) begin
            mem_addr  <= victim_dirty ? {victim_tag, index} : refill_addr;
            mem_wdata <= victim_block;
        end else if (state == cache_ctrl_pkg::WRITEBACK && mem_ready) begin
            mem_addr <= refill_addr;
        end
    end

    a_no_rw_overlap : assert property (
        @(posedge clk) disable iff (proc_reset) !(mem_read && mem_write)
    ) else $error("controller: mem_read and mem_write both high");

    // write-back request only up in WRITEBACK, processor held off meanwhile
    a_wb_stalls : assert property (
        @(posedge clk) disable iff (proc_reset)
        mem_write |-> (proc_stall && state == cache_ctrl_pkg::WRITEBACK)
    ) else $error("controller: write-back request without stall or outside WRITEBACK");

endmodule

/* design/cache_data_array.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_data_array (
    input  logic                    clk,
    input  logic                    proc_reset,
    input  cache_addr_pkg::index_t  index,
    input  cache_addr_pkg::offset_t offset,
    input  cache_ctrl_pkg::way_t    way,
    input  logic                    word_write,
    input  logic                    fill,
    input  cache_addr_pkg::word_t   wdata,
    input  cache_addr_pkg::block_t  fill_block,
    input  logic                    merge_write,
    output cache_addr_pkg::word_t   rdata_word,
    output cache_addr_pkg::block_t  victim_block
);

    cache_addr_pkg::block_t store [`CACHE_SETS][`CACHE_WAYS];

    cache_addr_pkg::block_t stored_block;
    cache_addr_pkg::block_t merged_block;

    assign stored_block = store[index][way];
    assign victim_block = stored_block;   // way points at the victim on a miss

    // refill data with the write word dropped in
    always_comb begin
        merged_block = fill_block;
        if (merge_write) begin
            merged_block[offset*`CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
        end
    end

    // read miss takes its word straight from the refill
    always_comb begin
        if (fill) begin
            rdata_word = merged_block[offset*`CACHE_WORD_W +: `CACHE_WORD_W];
        end else begin
            rdata_word = stored_block[offset*`CACHE_WORD_W +: `CACHE_WORD_W];
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            store[index][way] <= merged_block;
        end else if (word_write) begin
            store[index][way][offset*`CACHE_WORD_W +: `CACHE_WORD_W] <= wdata;
        end
    end

    // controller only writes on a hit or on a refill, never both
    a_one_update : assert property (
        @(posedge clk) disable iff (proc_reset) !(word_write && fill)
    ) else $error("data array: word write and fill in the same cycle");

endmodule

/* design/cache_tag_array.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tag_array (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  cache_addr_pkg::index_t index,
    input  cache_addr_pkg::tag_t   tag,
    input  logic                   touch,
    input  logic                   fill,
    input  cache_ctrl_pkg::way_t   access_way,
    input  logic                   set_dirty,
    output logic                   hit,
    output cache_ctrl_pkg::way_t   hit_way,
    output cache_ctrl_pkg::way_t   victim_way,
    output logic                   victim_dirty,
    output cache_addr_pkg::tag_t   victim_tag
);

    cache_addr_pkg::tag_t   tag_q   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] used_q  [`CACHE_SETS];

    logic [`CACHE_WAYS-1:0] way_hit;
    logic [`CACHE_WAYS-1:0] touch_mask;

    // compare every way of the selected set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = valid_q[index][w] && (tag_q[index][w] == tag);
            if (way_hit[w]) begin
                hit_way = cache_ctrl_pkg::way_t'(w);
            end
        end
    end

    assign hit = |way_hit;

    // way 0 used last means way 1 is the older one
    assign victim_way   = cache_ctrl_pkg::way_t'(used_q[index][0]);
    assign victim_dirty = valid_q[index][victim_way] && dirty_q[index][victim_way];
    assign victim_tag   = tag_q[index][victim_way];

    always_comb begin
        touch_mask             = '0;
        touch_mask[access_way] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                used_q[s]  <= '0;
            end
        end else begin
            if (touch) begin
                used_q[index] <= touch_mask;   // only the touched way stays marked
                if (set_dirty) begin
                    dirty_q[index][access_way] <= 1'b1;
                end
            end
            if (fill) begin
                valid_q[index][access_way] <= 1'b1;
                dirty_q[index][access_way] <= set_dirty;   // write miss allocates dirty
            end
        end
    end

    // tags only change on a refill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index][access_way] <= tag;
        end
    end

    // a block lives in at most one way, since fills only follow a miss
    a_single_hit : assert property (
        @(posedge clk) disable iff (proc_reset) $onehot0(way_hit)
    ) else $error("tag array: block resident in more than one way");

endmodule

/* design/cache_ctrl_pkg.sv */
`include "cache_macros.svh"

package cache_ctrl_pkg;

    // miss handling FSM
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WRITEBACK = 2'd1,   // dirty victim going out
        ALLOCATE  = 2'd2    // refill in flight
    } cache_state_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

endpackage

/* design/cache_addr_pkg.sv */
`include "cache_macros.svh"

package cache_addr_pkg;

    // processor word address and memory block address
    typedef logic [`PROC_ADDR_W-1:0] proc_addr_t;
    typedef logic [`MEM_ADDR_W-1:0]  mem_addr_t;

    // fields of a proc address
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    typedef logic [`CACHE_WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef logic [`CACHE_WORD_W*`CACHE_BLOCK_WORDS-1:0] block_t;

endpackage

/* design/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// data geometry
`define CACHE_WORD_W      32
`define CACHE_BLOCK_WORDS 4

// organization
`define CACHE_SETS        4
`define CACHE_WAYS        2

// address split, tag + index + offset = proc address
`define CACHE_TAG_W       26
`define CACHE_INDEX_W     2
`define CACHE_OFFSET_W    2

`define PROC_ADDR_W       30   // word address
`define MEM_ADDR_W        28   // block address

`endif
